// ==== common/dma_consts.svh ====
/*
 * Global widths for the write DMA path.
 * Data width must be a power of two bytes; byte lengths are whole words.
 * DMA_PAGE is the AXI4 burst boundary and must stay at 4096.
 */

`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// Address bus width
`define DMA_AW 32

// Data bus width, all byte lanes always written
`define DMA_DW 32

// Client byte length field, at most 64 KB - 4 per request
`define DMA_LENW 16

// No burst may cross this boundary
`define DMA_PAGE 4096

`endif

// ==== common/dma_pkg.sv ====
/*
 * Shared types for the write DMA path.
 * Only AXI4 write channels are described; AWID is one bit and always zero.
 * Widths come from dma_consts.svh.
 */

`default_nettype none

`include "dma_consts.svh"

package dma_pkg;

    // AXI4 burst type codes
    localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
    localparam logic [1:0] AXI_BURST_INCR  = 2'b01;

    // Write response code for success
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // One client transfer request
    typedef struct packed {
        logic [`DMA_AW-1:0]   addr;
        logic [`DMA_LENW-1:0] byte_len;   // Multiple of 4, never zero
        logic                 fixed;
        logic                 lock;
    } dma_req_t;

    // One legal burst, as handed to the AXI manager
    typedef struct packed {
        logic [`DMA_AW-1:0] addr;
        logic [7:0]         len;          // Beats minus one
        logic               fixed;
        logic               lock;
    } burst_ctx_t;

    // AW channel payload
    typedef struct packed {
        logic [`DMA_AW-1:0] addr;
        logic [7:0]         len;
        logic [2:0]         size;
        logic [1:0]         burst;
        logic               lock;
        logic               id;
    } axi_aw_t;

    // W channel payload
    typedef struct packed {
        logic [`DMA_DW-1:0]   data;
        logic [`DMA_DW/8-1:0] strb;
        logic                 last;
    } axi_w_t;

    // B channel payload
    typedef struct packed {
        logic [1:0] resp;
        logic       id;
    } axi_b_t;

endpackage

`default_nettype wire

// ==== axi_mgr_wr/ctx_skid.sv ====
/*
 * Two-entry registered valid/ready skid buffer.
 * o_ready is a flop output, so no path runs from i_ready to o_ready.
 * Full throughput while the consumer keeps i_ready high.
 */

`timescale 1ns/100ps
`default_nettype none

module ctx_skid #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     i_valid,
    output logic          o_ready,
    input  wire payload_t i_data,
    output logic          o_valid,
    output payload_t      o_data,
    input  wire logic     i_ready
);

    logic     out_valid;
    logic     skd_valid;
    payload_t out_data;
    payload_t skd_data;
    logic     out_free;

    // Head slot empties this cycle
    assign out_free = !out_valid || i_ready;

    assign o_ready = !skd_valid;
    assign o_valid = out_valid;
    assign o_data  = out_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            skd_valid <= 1'b0;
        end else if (out_free) begin
            // Skid entry drains first, otherwise take the input
            if (skd_valid) begin
                out_valid <= 1'b1;
                skd_valid <= 1'b0;
            end else begin
                out_valid <= i_valid;
            end
        end else if (i_valid && o_ready) begin
            // Head stalled, park the new entry
            skd_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data <= skd_valid ? skd_data : i_data;
        end
        if (!out_free && i_valid && o_ready) begin
            skd_data <= i_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/burst_splitter.sv ====
/*
 * Cuts one client request into AXI4 bursts of at most 256 beats (16 when fixed)
 * that never cross a 4 KB page. Only one request is outstanding at a time.
 * byte_len must be a nonzero multiple of the word size; low bits are ignored.
 * o_done is a single-cycle strobe carrying the worst B response seen.
 */

`timescale 1ns/100ps
`default_nettype none

`include "dma_consts.svh"

module burst_splitter (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire dma_pkg::dma_req_t     i_req,
    input  wire logic                  i_req_valid,
    output logic                       o_req_ready,
    output dma_pkg::burst_ctx_t        o_ctx,
    output logic                       o_ctx_valid,
    input  wire logic                  i_ctx_ready,
    input  wire logic                  i_b_seen,
    input  wire logic [1:0]            i_b_resp,
    output logic                       o_done,
    output logic [1:0]                 o_done_resp
);

    localparam int WB   = $clog2(`DMA_DW / 8);
    localparam int CNTW = `DMA_LENW - WB;
    localparam int PGW  = $clog2(`DMA_PAGE);

    dma_pkg::dma_req_t   rq;
    logic                rq_valid;
    logic                skid_ready;
    logic                busy;
    logic                started;
    logic                all_issued;

    logic [`DMA_AW-1:0]   addr_q;
    logic [`DMA_LENW-1:0] rem_q;
    logic [`DMA_AW-1:0]   cur_addr;
    logic [`DMA_LENW-1:0] cur_rem;

    logic [PGW:0]         page_bytes;
    logic [CNTW-1:0]      rem_words;
    logic [CNTW-1:0]      page_words;
    logic [CNTW-1:0]      cap_words;
    logic [CNTW-1:0]      beats;
    logic [`DMA_LENW-1:0] step_bytes;
    logic                 last_burst;
    logic                 ctx_fire;
    logic                 req_fire;

    logic [CNTW-1:0]      burst_cnt;
    logic [CNTW-1:0]      resp_cnt;
    logic [CNTW-1:0]      resp_next;
    logic [1:0]           worst_q;

    // Request stays at the skid head until completion
    ctx_skid #(
        .payload_t(dma_pkg::dma_req_t)
    ) u_req_skid (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_valid(i_req_valid && !busy),
        .o_ready(skid_ready),
        .i_data (i_req),
        .o_valid(rq_valid),
        .o_data (rq),
        .i_ready(o_done)
    );

    // Blocked from acceptance until o_done
    assign o_req_ready = skid_ready && !busy;
    assign req_fire    = i_req_valid && o_req_ready;

    // First burst comes straight from the skid head
    assign cur_addr = started ? addr_q : rq.addr;
    assign cur_rem  = started ? rem_q  : rq.byte_len;

    // Three limits, in words
    always_comb begin
        rem_words  = cur_rem[`DMA_LENW-1:WB];
        page_bytes = (PGW+1)'(`DMA_PAGE) - {1'b0, cur_addr[PGW-1:0]};
        page_words = CNTW'(page_bytes[PGW:WB]);
        cap_words  = rq.fixed ? CNTW'(16) : CNTW'(256);

        beats = rem_words;
        if (page_words < beats) begin
            beats = page_words;
        end
        if (cap_words < beats) begin
            beats = cap_words;
        end

        step_bytes = {beats, WB'(0)};
        last_burst = (beats == rem_words);
    end

    always_comb begin
        o_ctx.addr  = cur_addr;
        o_ctx.len   = 8'(beats - 1'b1);
        o_ctx.fixed = rq.fixed;
        o_ctx.lock  = rq.lock;
    end

    assign o_ctx_valid = rq_valid && !all_issued;
    assign ctx_fire    = o_ctx_valid && i_ctx_ready;

    // Walk address and remaining bytes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            started    <= 1'b0;
            all_issued <= 1'b0;
        end else begin
            if (req_fire) begin
                busy <= 1'b1;
            end else if (o_done) begin
                busy <= 1'b0;
            end

            if (o_done) begin
                started    <= 1'b0;
                all_issued <= 1'b0;
            end else if (ctx_fire) begin
                started <= 1'b1;
                if (last_burst) begin
                    all_issued <= 1'b1;
                end
            end
        end
    end

    // Payload registers, meaningful only while started
    always_ff @(posedge clk) begin
        if (ctx_fire) begin
            addr_q <= rq.fixed ? cur_addr : cur_addr + `DMA_AW'(step_bytes);
            rem_q  <= cur_rem - step_bytes;
        end
    end

    assign resp_next = resp_cnt + 1'b1;

    // Burst and response bookkeeping
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            burst_cnt <= '0;
            resp_cnt  <= '0;
            worst_q   <= dma_pkg::AXI_RESP_OKAY;
            o_done    <= 1'b0;
        end else begin
            o_done <= i_b_seen && all_issued && (resp_next == burst_cnt);

            if (req_fire) begin
                burst_cnt <= '0;
                resp_cnt  <= '0;
                worst_q   <= dma_pkg::AXI_RESP_OKAY;
            end else begin
                if (ctx_fire) begin
                    burst_cnt <= burst_cnt + 1'b1;
                end
                if (i_b_seen) begin
                    resp_cnt <= resp_next;
                    // Highest code wins
                    if (i_b_resp > worst_q) begin
                        worst_q <= i_b_resp;
                    end
                end
            end
        end
    end

    assign o_done_resp = worst_q;

endmodule

`default_nettype wire

// ==== axi_mgr_wr/axi_mgr_wr.sv ====
/*
 * AXI4 write manager. AW goes out as soon as a burst context is buffered, so
 * an address can run ahead of its data. W beats come from a valid/ready stream
 * and WLAST is generated from len. WSTRB is all ones and AWID is zero.
 * BREADY is tied high and every B handshake is reported upstream.
 */

`timescale 1ns/100ps
`default_nettype none

`include "dma_consts.svh"

module axi_mgr_wr (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire dma_pkg::burst_ctx_t  i_ctx,
    input  wire logic                 i_ctx_valid,
    output logic                      o_ctx_ready,
    input  wire logic                 i_wvalid,
    input  wire logic [`DMA_DW-1:0]   i_wdata,
    output logic                      o_wready,
    output dma_pkg::axi_aw_t          o_aw,
    output logic                      o_awvalid,
    input  wire logic                 i_awready,
    output dma_pkg::axi_w_t           o_w,
    output logic                      o_wvalid,
    input  wire logic                 i_wready,
    input  wire dma_pkg::axi_b_t      i_b,
    input  wire logic                 i_bvalid,
    output logic                      o_bready,
    output logic                      o_b_seen,
    output logic [1:0]                o_b_resp
);

    localparam logic [2:0] AXI_SIZE = 3'($clog2(`DMA_DW / 8));

    dma_pkg::burst_ctx_t ctx;
    logic                ctx_valid;
    logic                ctx_ready;
    logic                ctx_fire;
    logic                ctx_sent;

    logic                txn_active;
    logic [7:0]          txn_down_cnt;
    logic                w_fire;
    logic                txn_final_beat;

    // Head of this buffer is the next burst whose address is to go out
    ctx_skid #(
        .payload_t(dma_pkg::burst_ctx_t)
    ) u_ctx_skid (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_valid(i_ctx_valid),
        .o_ready(o_ctx_ready),
        .i_data (i_ctx),
        .o_valid(ctx_valid),
        .o_data (ctx),
        .i_ready(ctx_ready)
    );

    // Pop the head when the data path frees up and its address is
    // accepted now or already gone
    assign ctx_ready = (!txn_active || txn_final_beat) && (i_awready || ctx_sent);
    assign ctx_fire  = ctx_valid && ctx_ready;

    // One AW per burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctx_sent <= 1'b0;
        end else if (ctx_fire) begin
            ctx_sent <= 1'b0;
        end else if (o_awvalid && i_awready) begin
            ctx_sent <= 1'b1;
        end
    end

    assign o_awvalid = ctx_valid && !ctx_sent;

    always_comb begin
        o_aw.addr  = ctx.addr;
        o_aw.len   = ctx.len;
        o_aw.size  = AXI_SIZE;
        o_aw.burst = ctx.fixed ? dma_pkg::AXI_BURST_FIXED : dma_pkg::AXI_BURST_INCR;
        o_aw.lock  = ctx.lock;
        o_aw.id    = 1'b0;
    end

    // Data tracker
    assign w_fire         = o_wvalid && i_wready;
    assign txn_final_beat = w_fire && o_w.last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_active <= 1'b0;
        end else if (ctx_fire) begin
            txn_active <= 1'b1;
        end else if (txn_final_beat) begin
            txn_active <= 1'b0;
        end
    end

    // Beats left after the current one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_down_cnt <= '1;
        end else if (ctx_fire) begin
            txn_down_cnt <= ctx.len;
        end else if (w_fire) begin
            txn_down_cnt <= txn_down_cnt - 1'b1;
        end
    end

    // W only offered inside a burst so no beat leaves unaccounted
    assign o_wvalid = i_wvalid && txn_active;

    always_comb begin
        o_w.data = i_wdata;
        o_w.strb = '1;
        o_w.last = (txn_down_cnt == 8'd0);
    end

    assign o_wready = txn_active && i_wready;

    // Responses
    assign o_bready = 1'b1;
    assign o_b_seen = i_bvalid && o_bready;
    assign o_b_resp = i_b.resp;

endmodule

`default_nettype wire

// ==== hdl/dma_wr_top.sv ====
/*
 * Write-only DMA with one AXI4 manager port.
 * One client request at a time; completion is a one-cycle o_done strobe.
 * Data beats arrive on a valid/ready stream in address order.
 */

`timescale 1ns/100ps
`default_nettype none

`include "dma_consts.svh"

module dma_wr_top (
    input  wire logic                clk,
    input  wire logic                rst_n,
    // Client
    input  wire dma_pkg::dma_req_t   i_req,
    input  wire logic                i_req_valid,
    output logic                     o_req_ready,
    output logic                     o_done,
    output logic [1:0]               o_done_resp,
    // Data stream
    input  wire logic                i_wvalid,
    input  wire logic [`DMA_DW-1:0]  i_wdata,
    output logic                     o_wready,
    // AXI4 write channels
    output dma_pkg::axi_aw_t         o_aw,
    output logic                     o_awvalid,
    input  wire logic                i_awready,
    output dma_pkg::axi_w_t          o_w,
    output logic                     o_wvalid,
    input  wire logic                i_wready,
    input  wire dma_pkg::axi_b_t     i_b,
    input  wire logic                i_bvalid,
    output logic                     o_bready
);

    dma_pkg::burst_ctx_t ctx;
    logic                ctx_valid;
    logic                ctx_ready;
    logic                b_seen;
    logic [1:0]          b_resp;

    burst_splitter u_splitter (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (i_req),
        .i_req_valid(i_req_valid),
        .o_req_ready(o_req_ready),
        .o_ctx      (ctx),
        .o_ctx_valid(ctx_valid),
        .i_ctx_ready(ctx_ready),
        .i_b_seen   (b_seen),
        .i_b_resp   (b_resp),
        .o_done     (o_done),
        .o_done_resp(o_done_resp)
    );

    axi_mgr_wr u_mgr (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_ctx      (ctx),
        .i_ctx_valid(ctx_valid),
        .o_ctx_ready(ctx_ready),
        .i_wvalid   (i_wvalid),
        .i_wdata    (i_wdata),
        .o_wready   (o_wready),
        .o_aw       (o_aw),
        .o_awvalid  (o_awvalid),
        .i_awready  (i_awready),
        .o_w        (o_w),
        .o_wvalid   (o_wvalid),
        .i_wready   (i_wready),
        .i_b        (i_b),
        .i_bvalid   (i_bvalid),
        .o_bready   (o_bready),
        .o_b_seen   (b_seen),
        .o_b_resp   (b_resp)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
/*
 * Testbench clock and reset source.
 * 40 ns period, rst_n held low for the first 5 rising edges.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #20 o_clk = ~o_clk;
        end
    end

    // Release just after an edge so it never races the DUT flops
    initial begin
        o_rst_n = 1'b0;
        repeat (5) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/dma_wr_properties.sv ====
/*
 * AXI write channel checks, bound into axi_mgr_wr.
 * Beat count is tracked from the context pop, not from AW acceptance.
 */

`timescale 1ns/100ps
`default_nettype none

module dma_wr_properties (
    input wire logic             clk,
    input wire logic             rst_n,
    input wire dma_pkg::axi_aw_t i_aw,
    input wire logic             i_awvalid,
    input wire logic             i_awready,
    input wire dma_pkg::axi_w_t  i_w,
    input wire logic             i_wvalid,
    input wire logic             i_wready,
    input wire logic             i_ctx_fire,
    input wire logic [7:0]       i_ctx_len
);

    logic [8:0] beat_cnt;
    logic [7:0] cur_len;

    // Beats sent in the burst now on W
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            cur_len  <= '0;
        end else if (i_ctx_fire) begin
            beat_cnt <= '0;
            cur_len  <= i_ctx_len;
        end else if (i_wvalid && i_wready) begin
            beat_cnt <= beat_cnt + 9'd1;
        end
    end

    aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        i_awvalid && !i_awready |=> i_awvalid && $stable(i_aw))
        else $error("AW dropped or changed while stalled");

    w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        i_wvalid && !i_wready |=> i_wvalid && $stable(i_w))
        else $error("W dropped or changed while stalled");

    // WLAST exactly on beat len, so a burst has len + 1 beats
    wlast_count: assert property (@(posedge clk) disable iff (!rst_n)
        i_wvalid && i_wready |-> (i_w.last == (beat_cnt == {1'b0, cur_len})))
        else $error("WLAST not on beat len of the burst");

    no_extra_beat: assert property (@(posedge clk) disable iff (!rst_n)
        i_wvalid && i_wready |-> beat_cnt <= {1'b0, cur_len})
        else $error("W beat beyond the end of the burst");

endmodule

`default_nettype wire

// ==== verif/dma_wr_tb.sv ====
/*
 * Testbench for dma_wr_top with an AXI4 write subordinate model.
 * The model stalls AWREADY/WREADY at random and delays B at random.
 * Memory is a sparse word array, rebuilt for each test.
 */

`timescale 1ns/100ps
`default_nettype none

`include "dma_consts.svh"

module dma_wr_tb;

    localparam int TIMEOUT = 2000;

    logic                clk;
    logic                rst_n;
    dma_pkg::dma_req_t   i_req;
    logic                i_req_valid;
    logic                o_req_ready;
    logic                o_done;
    logic [1:0]          o_done_resp;
    logic                i_wvalid = 1'b0;
    logic [`DMA_DW-1:0]  i_wdata = '0;
    logic                o_wready;
    dma_pkg::axi_aw_t    o_aw;
    logic                o_awvalid;
    logic                i_awready = 1'b0;
    dma_pkg::axi_w_t     o_w;
    logic                o_wvalid;
    logic                i_wready = 1'b0;
    dma_pkg::axi_b_t     i_b = '0;
    logic                i_bvalid = 1'b0;
    logic                o_bready;

    // Test setup shared with the model
    integer              seed = 32'h76fe0c89;
    logic                stall_en = 1'b0;
    logic [31:0]         err_lo = '0;
    logic [31:0]         err_hi = '0;
    logic [31:0]         stream_base = '0;
    int                  stream_idx = 0;
    int                  stream_len = 0;
    string               cur_name = "none";
    logic                req_open = 1'b0;
    int                  done_cnt = 0;
    logic [1:0]          done_resp = '0;
    int                  errors = 0;
    int                  tests_run = 0;
    int                  tests_failed = 0;

    // Model state
    dma_pkg::axi_aw_t    exp_q[$];
    dma_pkg::axi_aw_t    aw_q[$];
    logic [1:0]          b_q[$];
    logic [31:0]         mem [logic [31:0]];
    dma_pkg::axi_aw_t    cur_aw;
    logic [31:0]         beat_addr;
    int                  beat_idx = 0;
    int                  b_wait = 0;

    tb_clk_gen u_clk (
        .o_clk  (clk),
        .o_rst_n(rst_n)
    );

    dma_wr_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (i_req),
        .i_req_valid(i_req_valid),
        .o_req_ready(o_req_ready),
        .o_done     (o_done),
        .o_done_resp(o_done_resp),
        .i_wvalid   (i_wvalid),
        .i_wdata    (i_wdata),
        .o_wready   (o_wready),
        .o_aw       (o_aw),
        .o_awvalid  (o_awvalid),
        .i_awready  (i_awready),
        .o_w        (o_w),
        .o_wvalid   (o_wvalid),
        .i_wready   (i_wready),
        .i_b        (i_b),
        .i_bvalid   (i_bvalid),
        .o_bready   (o_bready)
    );

    bind axi_mgr_wr dma_wr_properties u_props (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_aw      (o_aw),
        .i_awvalid (o_awvalid),
        .i_awready (i_awready),
        .i_w       (o_w),
        .i_wvalid  (o_wvalid),
        .i_wready  (i_wready),
        .i_ctx_fire(ctx_fire),
        .i_ctx_len (ctx.len)
    );

    // Reference burst list from words left, page room and 256 (16 if fixed)
    function automatic void expected_bursts(input logic [31:0] addr, input int len,
                                            input logic fixed);
        logic [31:0]      a;
        int               rem_w;
        int               page_w;
        int               beats;
        dma_pkg::axi_aw_t aw;
        a     = addr;
        rem_w = len / 4;
        while (rem_w > 0) begin
            page_w = (`DMA_PAGE - int'(a % `DMA_PAGE)) / 4;
            beats  = rem_w;
            if (page_w < beats) begin
                beats = page_w;
            end
            if (fixed && beats > 16) begin
                beats = 16;
            end else if (beats > 256) begin
                beats = 256;
            end
            aw.addr  = a;
            aw.len   = 8'(beats - 1);
            aw.size  = 3'd2;
            aw.burst = fixed ? dma_pkg::AXI_BURST_FIXED : dma_pkg::AXI_BURST_INCR;
            aw.lock  = 1'b0;
            aw.id    = 1'b0;
            exp_q.push_back(aw);
            // Fixed bursts all hit the same word
            if (!fixed) begin
                a = a + 32'(beats * 4);
            end
            rem_w = rem_w - beats;
        end
    endfunction

    task automatic check_aw(input string name, input dma_pkg::axi_aw_t exp,
                            input dma_pkg::axi_aw_t act);
        if (exp !== act) begin
            $display("MISMATCH %s aw: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] addr,
                              input logic [`DMA_DW-1:0] exp, input logic [`DMA_DW-1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s word @%h: expected %h, actual %h", name, addr, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s resp: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_run;
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("%s: timed out waiting for %s", cur_name, what);
        errors++;
        tests_failed++;
        finish_run();
    endtask

    // AXI subordinate, stream source and compare process
    always @(posedge clk) begin
        if (rst_n) begin
            // B must be taken the cycle it is offered
            if (i_bvalid && o_bready !== 1'b1) begin
                $display("MISMATCH %s bready: expected 1, actual %b", cur_name, o_bready);
                errors++;
            end
            if (o_awvalid && i_awready) begin
                aw_q.push_back(o_aw);
                if (exp_q.size() == 0) begin
                    $display("%s: unexpected extra AW at %h", cur_name, o_aw.addr);
                    errors++;
                end else begin
                    check_aw(cur_name, exp_q.pop_front(), o_aw);
                end
            end
            if (o_wvalid && i_wready) begin
                // Every byte lane is written
                if (o_w.strb !== {(`DMA_DW / 8){1'b1}}) begin
                    $display("MISMATCH %s strb: expected %h, actual %h", cur_name,
                             {(`DMA_DW / 8){1'b1}}, o_w.strb);
                    errors++;
                end
                if (aw_q.size() == 0) begin
                    $display("%s: W beat arrived before its address", cur_name);
                    errors++;
                end else begin
                    cur_aw = aw_q[0];
                    beat_addr = (cur_aw.burst == dma_pkg::AXI_BURST_FIXED) ?
                                cur_aw.addr : cur_aw.addr + 32'(beat_idx * 4);
                    mem[beat_addr] = o_w.data;
                    if (o_w.last !== (beat_idx == int'(cur_aw.len))) begin
                        $display("MISMATCH %s wlast beat %0d of burst at %h: expected %b, actual %b",
                                 cur_name, beat_idx, cur_aw.addr,
                                 beat_idx == int'(cur_aw.len), o_w.last);
                        errors++;
                    end
                    if (beat_idx == int'(cur_aw.len)) begin
                        // Error window picks the response of the whole burst
                        b_q.push_back((cur_aw.addr >= err_lo && cur_aw.addr < err_hi) ?
                                      2'b10 : dma_pkg::AXI_RESP_OKAY);
                        void'(aw_q.pop_front());
                        beat_idx = 0;
                    end else begin
                        beat_idx++;
                    end
                end
            end
            if (i_wvalid && o_wready) begin
                stream_idx++;
            end
            if (o_done) begin
                if (!req_open) begin
                    $display("%s: o_done with no request outstanding", cur_name);
                    errors++;
                end
                req_open  = 1'b0;
                done_cnt++;
                done_resp = o_done_resp;
            end
        end
        #1;
        i_awready = stall_en ? (($random(seed) & 7) != 0) : 1'b1;
        i_wready  = stall_en ? (($random(seed) & 7) != 0) : 1'b1;
        if (i_bvalid) begin
            // BREADY is tied high and B is taken in one cycle
            i_bvalid = 1'b0;
        end else if (b_q.size() != 0) begin
            if (b_wait > 0) begin
                b_wait--;
            end else begin
                i_bvalid   = 1'b1;
                i_b.resp   = b_q.pop_front();
                i_b.id     = 1'b0;
                b_wait     = $random(seed) & 3;
            end
        end
        // Consecutive words from the per-test base
        i_wvalid = rst_n && (stream_idx < stream_len);
        i_wdata  = stream_base + 32'(stream_idx);
    end

    task automatic run_req(input string name, input logic [31:0] addr, input int len,
                           input logic fixed, input logic [31:0] base, input logic stall,
                           input logic [31:0] lo, input logic [31:0] hi);
        int          errs_before;
        int          cnt;
        int          i;
        logic [1:0]  exp_resp;
        logic [31:0] a;
        errs_before = errors;
        @(posedge clk);
        #1;
        exp_q.delete();
        expected_bursts(addr, len, fixed);
        // Worst response over all bursts of the request
        exp_resp = dma_pkg::AXI_RESP_OKAY;
        for (i = 0; i < exp_q.size(); i++) begin
            if (exp_q[i].addr >= lo && exp_q[i].addr < hi) begin
                exp_resp = 2'b10;
            end
        end
        mem.delete();
        cur_name    = name;
        stall_en    = stall;
        err_lo      = lo;
        err_hi      = hi;
        stream_base = base;
        stream_idx  = 0;
        stream_len  = len / 4;
        done_cnt    = 0;

        i_req.addr     = addr;
        i_req.byte_len = 16'(len);
        i_req.fixed    = fixed;
        i_req.lock     = 1'b0;
        i_req_valid    = 1'b1;
        cnt = 0;
        @(posedge clk);
        while (!o_req_ready) begin
            cnt++;
            if (cnt >= TIMEOUT) begin
                abort_on_timeout("request acceptance");
            end
            @(posedge clk);
        end
        req_open = 1'b1;
        #1 i_req_valid = 0;

        // Client port stays closed until o_done
        cnt = 0;
        while (done_cnt == 0) begin
            cnt++;
            if (cnt >= TIMEOUT) begin
                abort_on_timeout("o_done");
            end
            if (o_req_ready) begin
                $display("%s: o_req_ready high while the request is outstanding", name);
                errors++;
            end
            @(posedge clk);
            #1;
        end
        // Extra cycles so a second o_done would be seen
        repeat (10) @(posedge clk);
        #1;

        check_resp(name, exp_resp, done_resp);
        if (done_cnt != 1) begin
            $display("%s: o_done seen %0d times instead of once", name, done_cnt);
            errors++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected bursts never issued", name, exp_q.size());
            errors++;
        end
        if (stream_idx != stream_len) begin
            $display("%s: %0d stream words taken, %0d offered", name, stream_idx, stream_len);
            errors++;
        end
        // Fixed mode leaves only the last stream word in memory
        for (i = 0; i < (fixed ? 1 : len / 4); i++) begin
            a = addr + 32'(i * 4);
            if (!mem.exists(a)) begin
                $display("%s: word at %h was never written", name, a);
                errors++;
            end else begin
                check_word(name, a, fixed ? base + 32'(len / 4 - 1) : base + 32'(i), mem[a]);
            end
        end

        tests_run++;
        if (errors == errs_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        int cnt;
        i_req       = '0;
        i_req_valid = 1'b0;
        cnt = 0;
        @(posedge clk);
        while (!rst_n) begin
            cnt++;
            if (cnt >= TIMEOUT) begin
                abort_on_timeout("reset release");
            end
            @(posedge clk);
        end

        run_req("single_64", 32'h0000_1000, 64, 1'b0, 32'h1000_0000, 1'b0, '0, '0);
        run_req("page_split", 32'h0000_0f80, 2048, 1'b0, 32'h2000_0000, 1'b0, '0, '0);
        run_req("full_page_stall", 32'h0000_8000, 4096, 1'b0, 32'h3000_0000, 1'b1, '0, '0);
        run_req("fixed_80", 32'h0000_5000, 80, 1'b1, 32'h4000_0000, 1'b1, '0, '0);
        // Second burst starts at 0x3000 inside the window
        run_req("slverr_2nd", 32'h0000_2f00, 1536, 1'b0, 32'h5000_0000, 1'b1,
                32'h0000_3000, 32'h0000_3400);

        finish_run();
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/dma_pkg.sv
axi_mgr_wr/ctx_skid.sv
hdl/burst_splitter.sv
axi_mgr_wr/axi_mgr_wr.sv
hdl/dma_wr_top.sv
verif/tb_clk_gen.sv
verif/dma_wr_properties.sv
verif/dma_wr_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the write DMA testbench with Verilator.
# Exit status is 0 only when the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dma_wr_tb -f list.f -o dma_wr_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/dma_wr_sim 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
